/* trenc_config.svh */
// trace encoder packet combiner configuration: widths, packet type codes and option bits
`ifndef TRENC_CONFIG_SVH
`define TRENC_CONFIG_SVH

`define TRENC_LANES       4
`define TRENC_PAYLOAD_W   40
`define TRENC_TIME_W      16
`define TRENC_PKT_W       64
`define TRENC_LEN_W       7
`define TRENC_HDR_W       8   // type 5, core 2, time flag 1
`define TRENC_CORE_W      2

// payload bits per packet kind
`define TRENC_W_BRA_ADDR   38
`define TRENC_W_BRA_NADDR  8
`define TRENC_W_ADDR       32
`define TRENC_W_SYNC_START 32
`define TRENC_W_TRAP_INT   34
`define TRENC_W_TRAP_EXC   36
`define TRENC_W_SUPPORT    8

`define TRENC_T_BRA_ADDR   5'h0A
`define TRENC_T_BRA_NADDR  5'h05
`define TRENC_T_ADDR       5'h06
`define TRENC_T_SYNC_START 5'h0B
`define TRENC_T_TRAP_INT   5'h11
`define TRENC_T_TRAP_EXC   5'h0C
`define TRENC_T_SUPPORT    5'h02

`define TRENC_IOPTION      2'b10  // full address, no compression

`endif

/* trenc_pkg.sv */
// trace encoder packet combiner types: lane formats, lane records and packet words
`include "trenc_config.svh"

package trenc_pkg;

  typedef enum logic [1:0] {
    FORMAT0 = 2'd0,  // unused
    FORMAT1 = 2'd1,  // branch
    FORMAT2 = 2'd2,  // address
    FORMAT3 = 2'd3   // sync
  } pkt_format_e;

  typedef enum logic [1:0] {
    SF_START     = 2'd0,
    SF_TRAP      = 2'd1,
    SF_BRA_ADDR  = 2'd2,
    SF_BRA_NADDR = 2'd3
  } sync_sformat_e;

  // one instruction lane as delivered per cycle
  typedef struct packed {
    logic                         vld;
    pkt_format_e                  fmt;
    sync_sformat_e                sfmt;
    logic                         intr;  // trap is an interrupt
    logic [`TRENC_PAYLOAD_W-1:0]  payload;
  } lane_in_t;

  typedef struct packed {
    logic                     vld;
    logic [`TRENC_LEN_W-1:0]  len;   // packet length in bits
    logic [`TRENC_PKT_W-1:0]  word;
  } pkt_t;

  typedef struct packed {
    logic [`TRENC_PAYLOAD_W-1:0]  payload;
    logic [`TRENC_TIME_W-1:0]     tstamp;
    logic                         tflag;
    logic [`TRENC_CORE_W-1:0]     core;
    logic [4:0]                   ptype;
  } word_timed_t;

  typedef struct packed {
    logic [`TRENC_TIME_W-1:0]     pad;
    logic [`TRENC_PAYLOAD_W-1:0]  payload;
    logic                         tflag;
    logic [`TRENC_CORE_W-1:0]     core;
    logic [4:0]                   ptype;
  } word_untimed_t;

  // same packet word, with or without the timestamp after the header
  typedef union packed {
    word_timed_t    timed;
    word_untimed_t  untimed;
  } pkt_word_u;

endpackage

/* trenc_support_gen.sv */
// trace state tracking and start, lost and stop support packet generation
`include "trenc_config.svh"

module trenc_support_gen (
  input  logic                      trenc_gclk_i,
  input  logic                      trenc_rstn_i,
  input  logic                      enable_i,
  input  logic                      start_i,
  input  logic                      stop_i,
  input  logic                      lost_i,
  input  logic                      inst_mode_i,
  input  logic                      timectr_i,
  input  logic [`TRENC_CORE_W-1:0]  core_id_i,
  output trenc_pkg::pkt_t           support_o
);

  localparam logic [`TRENC_LEN_W-1:0] HDR_LEN  = `TRENC_HDR_W;
  localparam logic [`TRENC_LEN_W-1:0] TIME_LEN = `TRENC_TIME_W;
  localparam logic [`TRENC_LEN_W-1:0] SUP_LEN  = `TRENC_W_SUPPORT;

  typedef enum logic {IDLE, TRACING} trc_state_e;

  trc_state_e state_q, state_d;
  logic started, started_q, started_rise;
  logic trace_start;
  logic stop_p, stop_q;
  logic lost_q;
  logic enc_mode, sup_en, sup_vld;
  logic [1:0] qual;
  trenc_pkg::pkt_word_u word;
  logic [`TRENC_PAYLOAD_W-1:0] sup_payload;

  assign started      = enable_i & start_i;
  assign started_rise = started & ~started_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (started_rise) state_d = TRACING;
      TRACING: if (!started) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  assign trace_start = (state_q == IDLE) && (state_d == TRACING);

  always_ff @(posedge trenc_gclk_i or negedge trenc_rstn_i) begin
    if (!trenc_rstn_i) begin
      state_q   <= IDLE;
      started_q <= 1'b0;
      stop_p    <= 1'b0;
      stop_q    <= 1'b0;
      lost_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      started_q <= started;
      stop_p    <= stop_i;
      stop_q    <= stop_p;  // stop reported two cycles late
      lost_q    <= lost_i;
    end
  end

  assign enc_mode = stop_q ? 1'b0 : inst_mode_i;
  assign sup_vld  = trace_start | lost_q | stop_q;

  // start over lost over stop
  always_comb begin
    sup_en = 1'b1;
    qual   = 2'b00;
    if (!trace_start && lost_q) begin
      qual = 2'b10;
    end else if (!trace_start && stop_q) begin
      sup_en = 1'b0;
      qual   = 2'b01;
    end
  end

  assign sup_payload = {{(`TRENC_PAYLOAD_W-`TRENC_W_SUPPORT){1'b0}},
                        2'b00, `TRENC_IOPTION, qual, enc_mode, sup_en};

  always_comb begin
    word = '0;
    if (timectr_i) begin
      word.timed.payload = sup_payload;
      word.timed.tstamp  = '0;  // support time is always zero
      word.timed.tflag   = 1'b1;
      word.timed.core    = core_id_i;
      word.timed.ptype   = `TRENC_T_SUPPORT;
    end else begin
      word.untimed.payload = sup_payload;
      word.untimed.tflag   = 1'b0;
      word.untimed.core    = core_id_i;
      word.untimed.ptype   = `TRENC_T_SUPPORT;
    end
  end

  assign support_o.vld  = sup_vld;
  assign support_o.len  = sup_vld ? HDR_LEN + (timectr_i ? TIME_LEN : '0) + SUP_LEN : '0;
  assign support_o.word = sup_vld ? word : '0;

endmodule

/* trenc_lane_fmt.sv */
// one instruction lane: registers the lane input and encodes it into a packet word
`include "trenc_config.svh"

module trenc_lane_fmt (
  input  logic                      trenc_gclk_i,
  input  logic                      trenc_rstn_i,
  input  trenc_pkg::lane_in_t       lane_i,
  input  logic                      timectr_i,
  input  logic [`TRENC_CORE_W-1:0]  core_id_i,
  input  logic [`TRENC_TIME_W-1:0]  itime_i,
  output trenc_pkg::pkt_t           pkt_o
);

  localparam logic [`TRENC_LEN_W-1:0] HDR_LEN  = `TRENC_HDR_W;
  localparam logic [`TRENC_LEN_W-1:0] TIME_LEN = `TRENC_TIME_W;

  logic vld_q, intr_q;
  trenc_pkg::pkt_format_e fmt_q;
  trenc_pkg::sync_sformat_e sfmt_q;
  logic [`TRENC_PAYLOAD_W-1:0] pay_q;
  logic [`TRENC_PAYLOAD_W-1:0] pay_mask;
  logic kind_ok, pkt_vld;
  logic [4:0] ptype;
  logic [`TRENC_LEN_W-1:0] pay_w;
  trenc_pkg::pkt_word_u word;

  always_ff @(posedge trenc_gclk_i or negedge trenc_rstn_i) begin
    if (!trenc_rstn_i) begin
      vld_q  <= 1'b0;
      fmt_q  <= trenc_pkg::FORMAT0;
      sfmt_q <= trenc_pkg::SF_START;
      intr_q <= 1'b0;
    end else begin
      vld_q  <= lane_i.vld;
      fmt_q  <= lane_i.fmt;
      sfmt_q <= lane_i.sfmt;
      intr_q <= lane_i.intr;
    end
  end

  always_ff @(posedge trenc_gclk_i) begin
    pay_q <= lane_i.payload;
  end

  // format and sub-format to packet type and payload width
  always_comb begin
    kind_ok = 1'b1;
    ptype   = '0;
    pay_w   = '0;
    case (fmt_q)
      trenc_pkg::FORMAT1: begin
        if (sfmt_q == trenc_pkg::SF_BRA_ADDR) begin
          ptype = `TRENC_T_BRA_ADDR;
          pay_w = `TRENC_W_BRA_ADDR;
        end else if (sfmt_q == trenc_pkg::SF_BRA_NADDR) begin
          ptype = `TRENC_T_BRA_NADDR;
          pay_w = `TRENC_W_BRA_NADDR;
        end else begin
          kind_ok = 1'b0;
        end
      end
      trenc_pkg::FORMAT2: begin  // sub-format not used
        ptype = `TRENC_T_ADDR;
        pay_w = `TRENC_W_ADDR;
      end
      trenc_pkg::FORMAT3: begin
        if (sfmt_q == trenc_pkg::SF_START) begin
          ptype = `TRENC_T_SYNC_START;
          pay_w = `TRENC_W_SYNC_START;
        end else if (sfmt_q == trenc_pkg::SF_TRAP && intr_q) begin
          ptype = `TRENC_T_TRAP_INT;
          pay_w = `TRENC_W_TRAP_INT;
        end else if (sfmt_q == trenc_pkg::SF_TRAP) begin
          ptype = `TRENC_T_TRAP_EXC;
          pay_w = `TRENC_W_TRAP_EXC;
        end else begin
          kind_ok = 1'b0;
        end
      end
      default: kind_ok = 1'b0;
    endcase
  end

  assign pay_mask = ~({`TRENC_PAYLOAD_W{1'b1}} << pay_w);

  always_comb begin
    word = '0;
    if (timectr_i) begin
      word.timed.payload = pay_q & pay_mask;
      word.timed.tstamp  = itime_i;  // live time of the output cycle
      word.timed.tflag   = 1'b1;
      word.timed.core    = core_id_i;
      word.timed.ptype   = ptype;
    end else begin
      word.untimed.payload = pay_q & pay_mask;
      word.untimed.tflag   = 1'b0;
      word.untimed.core    = core_id_i;
      word.untimed.ptype   = ptype;
    end
  end

  assign pkt_vld    = vld_q & kind_ok;
  assign pkt_o.vld  = pkt_vld;
  assign pkt_o.len  = pkt_vld ? HDR_LEN + (timectr_i ? TIME_LEN : '0) + pay_w : '0;
  assign pkt_o.word = pkt_vld ? word : '0;

endmodule

/* trenc_pkt_compact.sv */
// support packet override and compaction of valid lane packets onto the output slots
`include "trenc_config.svh"

module trenc_pkt_compact (
  input  trenc_pkg::pkt_t lanes_i [`TRENC_LANES],
  input  trenc_pkg::pkt_t support_i,
  output trenc_pkg::pkt_t slots_o [`TRENC_LANES]
);

  always_comb begin
    int unsigned idx;
    idx = 0;
    for (int j = 0; j < `TRENC_LANES; j++) begin
      slots_o[j] = '0;
    end
    if (support_i.vld) begin
      // replaces lane 0, lanes above are dropped
      slots_o[0] = support_i;
    end else begin
      for (int i = 0; i < `TRENC_LANES; i++) begin
        if (lanes_i[i].vld) begin
          slots_o[idx] = lanes_i[i];  // next free slot, lane order kept
          idx = idx + 1;
        end
      end
    end
  end

endmodule

/* trenc_pktcomb.sv */
// trace encoder packet combiner top: support path, lane formatters and slot compactor
`include "trenc_config.svh"

module trenc_pktcomb (
  input  logic                      trenc_gclk_i,
  input  logic                      trenc_rstn_i,
  input  logic                      enable_i,
  input  logic                      start_i,
  input  logic                      stop_i,
  input  logic                      lost_i,
  input  logic                      inst_mode_i,
  input  logic                      timectr_i,
  input  logic [`TRENC_CORE_W-1:0]  core_id_i,
  input  logic [`TRENC_TIME_W-1:0]  itime_i,
  input  trenc_pkg::lane_in_t       lanes_i [`TRENC_LANES],
  output trenc_pkg::pkt_t           slots_o [`TRENC_LANES]
);

  trenc_pkg::pkt_t support;
  trenc_pkg::pkt_t lane_pkt [`TRENC_LANES];

  trenc_support_gen u_support (
    .trenc_gclk_i (trenc_gclk_i),
    .trenc_rstn_i (trenc_rstn_i),
    .enable_i     (enable_i),
    .start_i      (start_i),
    .stop_i       (stop_i),
    .lost_i       (lost_i),
    .inst_mode_i  (inst_mode_i),
    .timectr_i    (timectr_i),
    .core_id_i    (core_id_i),
    .support_o    (support)
  );

  for (genvar g = 0; g < `TRENC_LANES; g++) begin : g_lane
    trenc_lane_fmt u_lane_fmt (
      .trenc_gclk_i (trenc_gclk_i),
      .trenc_rstn_i (trenc_rstn_i),
      .lane_i       (lanes_i[g]),
      .timectr_i    (timectr_i),
      .core_id_i    (core_id_i),
      .itime_i      (itime_i),
      .pkt_o        (lane_pkt[g])
    );
  end

  trenc_pkt_compact u_compact (
    .lanes_i   (lane_pkt),
    .support_i (support),
    .slots_o   (slots_o)
  );

endmodule

/* trenc_pktcomb_assert.sv */
// output slot properties of the packet combiner, bound into the top level
`include "trenc_config.svh"

module trenc_pktcomb_assert (
  input logic             trenc_gclk_i,
  input logic             trenc_rstn_i,
  input trenc_pkg::pkt_t  slots_i [`TRENC_LANES],
  input trenc_pkg::pkt_t  support_i
);
  timeunit 1ns;
  timeprecision 100ps;

  for (genvar g = 0; g < `TRENC_LANES; g++) begin : g_slot
    // idle slots carry nothing
    a_idle_zero: assert property (@(posedge trenc_gclk_i) disable iff (!trenc_rstn_i)
      !slots_i[g].vld |-> (slots_i[g].len == '0 && slots_i[g].word == '0))
      else $error("slot %0d invalid but not zero", g);

    if (g > 0) begin : g_upper
      a_contig: assert property (@(posedge trenc_gclk_i) disable iff (!trenc_rstn_i)
        slots_i[g].vld |-> slots_i[g-1].vld)
        else $error("slot %0d valid above an empty slot", g);

      a_sup_alone: assert property (@(posedge trenc_gclk_i) disable iff (!trenc_rstn_i)
        support_i.vld |-> !slots_i[g].vld)
        else $error("slot %0d valid beside a support packet", g);
    end
  end

endmodule

bind trenc_pktcomb trenc_pktcomb_assert u_pktcomb_assert (
  .trenc_gclk_i (trenc_gclk_i),
  .trenc_rstn_i (trenc_rstn_i),
  .slots_i      (slots_o),
  .support_i    (support)
);

/* tb_trenc_pktcomb.sv */
// testbench for the trace encoder packet combiner, driven and checked from a stimulus file
`include "trenc_config.svh"

module tb_trenc_pktcomb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_LINES = 64;

  logic                      trenc_gclk;
  logic                      trenc_rstn;
  logic                      enable;
  logic                      start;
  logic                      stop;
  logic                      lost;
  logic                      inst_mode;
  logic                      timectr;
  logic [`TRENC_CORE_W-1:0]  core_id;
  logic [`TRENC_TIME_W-1:0]  itime;
  trenc_pkg::lane_in_t       lanes [`TRENC_LANES];
  trenc_pkg::pkt_t           slots [`TRENC_LANES];

  // one record per cycle
  logic [7:0]   ctrl_mem [MAX_LINES];
  logic [15:0]  time_mem [MAX_LINES];
  logic [45:0]  lane_mem [MAX_LINES][`TRENC_LANES];
  logic [71:0]  exp_mem  [MAX_LINES][`TRENC_LANES];
  int n_lines;

  int err_cnt;
  int check_cnt;
  int cycle_cnt;
  int limit;

  trenc_pktcomb UUT (
    .trenc_gclk_i (trenc_gclk),
    .trenc_rstn_i (trenc_rstn),
    .enable_i     (enable),
    .start_i      (start),
    .stop_i       (stop),
    .lost_i       (lost),
    .inst_mode_i  (inst_mode),
    .timectr_i    (timectr),
    .core_id_i    (core_id),
    .itime_i      (itime),
    .lanes_i      (lanes),
    .slots_o      (slots)
  );

  always #2 trenc_gclk = ~trenc_gclk;

  task automatic load_stimulus();
    int fd;
    int cnt;
    string line;
    logic [7:0]  c;
    logic [15:0] t;
    logic [45:0] l0, l1, l2, l3;
    logic [71:0] s0, s1, s2, s3;
    n_lines = 0;
    fd = $fopen("trenc_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      err_cnt = err_cnt + 1;
      return;
    end
    while (!$feof(fd) && n_lines < MAX_LINES) begin
      line = "";
      void'($fgets(line, fd));
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                    c, t, l0, l1, l2, l3, s0, s1, s2, s3);
      if (cnt == 10) begin  // comment and blank lines fall out here
        ctrl_mem[n_lines]    = c;
        time_mem[n_lines]    = t;
        lane_mem[n_lines][0] = l0;
        lane_mem[n_lines][1] = l1;
        lane_mem[n_lines][2] = l2;
        lane_mem[n_lines][3] = l3;
        exp_mem[n_lines][0]  = s0;
        exp_mem[n_lines][1]  = s1;
        exp_mem[n_lines][2]  = s2;
        exp_mem[n_lines][3]  = s3;
        n_lines = n_lines + 1;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_line(input int k);
    core_id   <= ctrl_mem[k][7:6];
    timectr   <= ctrl_mem[k][5];
    inst_mode <= ctrl_mem[k][4];
    lost      <= ctrl_mem[k][3];
    stop      <= ctrl_mem[k][2];
    start     <= ctrl_mem[k][1];
    enable    <= ctrl_mem[k][0];
    itime     <= time_mem[k];
    for (int i = 0; i < `TRENC_LANES; i++) begin
      lanes[i] <= lane_mem[k][i];
    end
  endtask

  task automatic check_slots(input int k);
    trenc_pkg::pkt_t exp;
    for (int j = 0; j < `TRENC_LANES; j++) begin
      exp = exp_mem[k][j];
      check_cnt = check_cnt + 3;
      assert (slots[j].vld === exp.vld) else begin
        $display("[ERROR] line %0d slots_o[%0d].vld got %h expected %h",
                 k, j, slots[j].vld, exp.vld);
        err_cnt = err_cnt + 1;
      end
      assert (slots[j].len === exp.len) else begin
        $display("[ERROR] line %0d slots_o[%0d].len got %h expected %h",
                 k, j, slots[j].len, exp.len);
        err_cnt = err_cnt + 1;
      end
      assert (slots[j].word === exp.word) else begin
        $display("[ERROR] line %0d slots_o[%0d].word got %h expected %h",
                 k, j, slots[j].word, exp.word);
        err_cnt = err_cnt + 1;
      end
    end
  endtask

  task automatic report_and_finish();
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  initial begin
    trenc_gclk = 1'b0;
    trenc_rstn = 1'b0;
    enable     = 1'b0;
    start      = 1'b0;
    stop       = 1'b0;
    lost       = 1'b0;
    inst_mode  = 1'b0;
    timectr    = 1'b0;
    core_id    = '0;
    itime      = '0;
    for (int i = 0; i < `TRENC_LANES; i++) begin
      lanes[i] = '0;
    end
    err_cnt   = 0;
    check_cnt = 0;
    load_stimulus();
    limit = n_lines + 20;
    if (n_lines == 0) begin
      $display("no stimulus lines were read");
      err_cnt = err_cnt + 1;
    end
    repeat (8) @(posedge trenc_gclk);
    trenc_rstn <= 1'b1;
    for (int k = 0; k < n_lines; k++) begin
      @(posedge trenc_gclk);
      drive_line(k);
      @(negedge trenc_gclk);  // outputs settled mid cycle
      check_slots(k);
    end
    @(posedge trenc_gclk);
    report_and_finish();
  end

  // run guard after reset release
  always @(posedge trenc_gclk) begin
    if (trenc_rstn) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > limit) begin
        $display("timeout: the run did not end within %0d cycles", limit);
        err_cnt = err_cnt + 1;
        report_and_finish();
      end
    end else begin
      cycle_cnt <= 0;
    end
  end

endmodule

/* trenc_stimulus.txt */
# ctrl{core[1:0],timectr,mode,lost,stop,start,enable} itime lane0..lane3 (46b)
# then expected slot0..slot3 as {vld,len[6:0],word[63:0]}
40 0000 000000000000 000000000000 000000000000 000000000000 000000000000000000 000000000000000000 000000000000000000 000000000000000000
40 0000 2CFFFFFFFFFF 2E12345678AB 309876543210 380011223344 000000000000000000 000000000000000000 000000000000000000 000000000000000000
40 0000 3BFFFFFFFFFF 3AFFFFFFFFFF 000000000000 000000000000 AE00003FFFFFFFFF2A 90000000000000AB25 A80000007654321026 A8000000112233442B
40 0000 2C4000000001 2E00000000C5 3000DEADBEEF 3A0123456789 AA000003FFFFFFFF31 AC00000FFFFFFFFF2C 000000000000000000 000000000000000000
60 BEEF 3800CAFEF00D 3B0300000001 000000000000 000000000000 BE0000000001BEEFAA A000000000C5BEEFA5 B800DEADBEEFBEEFA6 BC0123456789BEEFAC
60 0042 000000000000 301111111111 000000000000 2E2222222222 B800CAFEF00D0042AB BA03000000010042B1 000000000000000000 000000000000000000
40 0000 285555555555 000000000000 2C0000000777 000000000000 A80000001111111126 900000000000002225 000000000000000000 000000000000000000
40 0000 000000000000 000000000000 000000000000 000000000000 AE000000000007772A 000000000000000000 000000000000000000 000000000000000000
53 0000 30AAAAAAAAAA 30BBBBBBBBBB 000000000000 000000000000 900000000000002322 000000000000000000 000000000000000000 000000000000000000
53 0000 000000000000 000000000000 000000000000 000000000000 A8000000AAAAAAAA26 A8000000BBBBBBBB26 000000000000000000 000000000000000000
50 0000 000000000000 000000000000 000000000000 000000000000 000000000000000000 000000000000000000 000000000000000000 000000000000000000
73 9999 000000000000 000000000000 000000000000 000000000000 A000000000230000A2 000000000000000000 000000000000000000 000000000000000000
58 0000 2E00000000F1 2E00000000F2 2E00000000F3 000000000000 000000000000000000 000000000000000000 000000000000000000 000000000000000000
50 0000 000000000000 000000000000 000000000000 000000000000 900000000000002B22 000000000000000000 000000000000000000 000000000000000000
54 0000 300000001234 000000000000 000000000000 000000000000 000000000000000000 000000000000000000 000000000000000000 000000000000000000
50 0000 300000005678 000000000000 000000000000 000000000000 A80000000000123426 000000000000000000 000000000000000000 000000000000000000
50 0000 000000000000 000000000000 000000000000 000000000000 900000000000002422 000000000000000000 000000000000000000 000000000000000000
40 0000 000000000000 000000000000 000000000000 000000000000 000000000000000000 000000000000000000 000000000000000000 000000000000000000
44 0000 000000000000 000000000000 000000000000 000000000000 000000000000000000 000000000000000000 000000000000000000 000000000000000000
48 0000 000000000000 000000000000 000000000000 000000000000 000000000000000000 000000000000000000 000000000000000000 000000000000000000
73 0101 000000000000 000000000000 000000000000 000000000000 A000000000210000A2 000000000000000000 000000000000000000 000000000000000000
70 0000 000000000000 000000000000 000000000000 000000000000 000000000000000000 000000000000000000 000000000000000000 000000000000000000
44 0000 000000000000 000000000000 000000000000 000000000000 000000000000000000 000000000000000000 000000000000000000 000000000000000000
58 0000 000000000000 000000000000 000000000000 000000000000 000000000000000000 000000000000000000 000000000000000000 000000000000000000
50 0000 000000000000 000000000000 000000000000 000000000000 900000000000002922 000000000000000000 000000000000000000 000000000000000000
40 0000 000000000000 000000000000 000000000000 000000000000 000000000000000000 000000000000000000 000000000000000000 000000000000000000

/* vlog.f */
+incdir+.
trenc_pkg.sv
trenc_support_gen.sv
trenc_lane_fmt.sv
trenc_pkt_compact.sv
trenc_pktcomb.sv
trenc_pktcomb_assert.sv
tb_trenc_pktcomb.sv

/* run.sh */
#!/bin/sh
# build and run the packet combiner testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_trenc_pktcomb -f vlog.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Everything OK$"; then
  exit 0
fi
exit 1
